/* Makefile */
VERILATOR := verilator
VFLAGS    := --binary --assert -j 0
TOP       := csr_subsystem_tb
FILELIST  := csr_subsystem.f
OBJDIR    := obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)
	@out="$$(./$(OBJDIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "sim passed"

clean:
	rm -rf $(OBJDIR)

/* cs_registers.sv */
////////////////////////////////////////////////////////////
// CSR file: constants, MSCRATCH, MEPC and loop access
// Reads are combinational, writes land on the next edge
// Unmapped reads give zero and raise the illegal flag
// Exception saves override CSR writes to MEPC
////////////////////////////////////////////////////////////

`include "csr_config.svh"

module cs_registers
(
  input  logic                                   clk,
  input  logic                                   rst_n,

  // Hart identity
  input  csr_pkg::hart_id_t                      core_id_i,
  input  csr_pkg::hart_id_t                      cluster_id_i,

  // Access port
  input  csr_pkg::csr_req_t                      csr_req_i,
  output csr_pkg::csr_data_t                     csr_rdata_o,
  output logic                                   csr_illegal_o,

  // Exception PC capture
  input  csr_pkg::csr_data_t                     curr_pc_if_i,
  input  csr_pkg::csr_data_t                     curr_pc_id_i,
  input  logic                                   save_pc_if_i,
  input  logic                                   save_pc_id_i,
  output csr_pkg::csr_data_t                     epcr_o,

  // Loop bank state and write port
  input  csr_pkg::csr_data_t [`HWLOOP_REGS-1:0]  hwlp_start_i,
  input  csr_pkg::csr_data_t [`HWLOOP_REGS-1:0]  hwlp_end_i,
  input  csr_pkg::csr_data_t [`HWLOOP_REGS-1:0]  hwlp_counter_i,
  output hwlp_pkg::hwlp_wr_t                     hwlp_wr_o
);

  // Three addresses per loop, fourth slot unused
  localparam int unsigned HWLP_SPAN = 4 * `HWLOOP_REGS;

  csr_pkg::csr_data_t    mscratch_q;
  csr_pkg::csr_data_t    mepc_q;

  logic                  is_constant;
  logic                  is_register;
  logic                  is_hwlp;
  logic                  is_readonly;
  logic                  illegal_addr;
  logic                  write_en;

  csr_pkg::csr_data_t    constant_rdata;
  csr_pkg::csr_data_t    register_rdata;
  csr_pkg::csr_data_t    hwlp_rdata;
  csr_pkg::csr_data_t    old_value;
  csr_pkg::csr_data_t    new_value;

  csr_pkg::csr_addr_t    hwlp_offset;
  hwlp_pkg::hwlp_id_t    hwlp_id;
  hwlp_pkg::hwlp_field_e hwlp_field;

  ////////////////////////////////////////////////////////////
  // Address decode
  ////////////////////////////////////////////////////////////

  // Top two bits set mark read-only space
  assign is_readonly = (csr_req_i.addr[11:10] == 2'b11);

  // Constants
  always_comb
  begin
    constant_rdata = '0;
    is_constant    = 1'b1;
    case (csr_req_i.addr)
      `CSR_ADDR_MCPUID:  constant_rdata = `CSR_MCPUID_VAL;
      `CSR_ADDR_MIMPID:  constant_rdata = `CSR_MIMPID_VAL;
      // Hart ID, cluster above core
      `CSR_ADDR_MHARTID: constant_rdata = {22'b0, cluster_id_i, core_id_i};
      default:           is_constant = 1'b0;
    endcase
  end

  // Machine registers
  always_comb
  begin
    register_rdata = '0;
    is_register    = 1'b1;
    case (csr_req_i.addr)
      `CSR_ADDR_MSCRATCH: register_rdata = mscratch_q;
      `CSR_ADDR_MEPC:     register_rdata = mepc_q;
      default:            is_register = 1'b0;
    endcase
  end

  // Loop window, offset bits [1:0] select the field
  assign hwlp_offset = csr_req_i.addr - `CSR_ADDR_HWLP_BASE;
  assign hwlp_id     = hwlp_pkg::hwlp_id_t'(hwlp_offset[11:2]);
  assign hwlp_field  = hwlp_pkg::hwlp_field_e'(hwlp_offset[1:0]);
  assign is_hwlp     = (csr_req_i.addr >= `CSR_ADDR_HWLP_BASE) &&
                       (hwlp_offset < csr_pkg::csr_addr_t'(HWLP_SPAN)) &&
                       (hwlp_offset[1:0] != 2'b11);

  always_comb
  begin
    case (hwlp_field)
      hwlp_pkg::START:   hwlp_rdata = hwlp_start_i[hwlp_id];
      hwlp_pkg::END:     hwlp_rdata = hwlp_end_i[hwlp_id];
      hwlp_pkg::COUNTER: hwlp_rdata = hwlp_counter_i[hwlp_id];
      default:           hwlp_rdata = '0;
    endcase
  end

  ////////////////////////////////////////////////////////////
  // Read mux and operation
  ////////////////////////////////////////////////////////////

  assign illegal_addr = !(is_constant || is_register || is_hwlp);

  // Zero when nothing matches
  always_comb
  begin
    if (is_constant)
      old_value = constant_rdata;
    else if (is_register)
      old_value = register_rdata;
    else if (is_hwlp)
      old_value = hwlp_rdata;
    else
      old_value = '0;
  end

  assign csr_rdata_o   = old_value;
  assign csr_illegal_o = illegal_addr;

  // Merge with the pre-edge contents
  always_comb
  begin
    case (csr_req_i.op)
      csr_pkg::WRITE: new_value = csr_req_i.wdata;
      csr_pkg::SET:   new_value = old_value | csr_req_i.wdata;
      csr_pkg::CLEAR: new_value = old_value & ~csr_req_i.wdata;
      default:        new_value = old_value;
    endcase
  end

  // Drop on NONE, read-only or unmapped
  assign write_en = (csr_req_i.op != csr_pkg::NONE) && !is_readonly && !illegal_addr;

  ////////////////////////////////////////////////////////////
  // Machine registers
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      mscratch_q <= '0;
      mepc_q     <= '0;
    end
    else
    begin
      if (write_en && (csr_req_i.addr == `CSR_ADDR_MSCRATCH))
        mscratch_q <= new_value;

      // IF save first, then ID save, then CSR write
      if (save_pc_if_i)
        mepc_q <= curr_pc_if_i;
      else if (save_pc_id_i)
        mepc_q <= curr_pc_id_i;
      else if (write_en && (csr_req_i.addr == `CSR_ADDR_MEPC))
        mepc_q <= new_value;
    end
  end

  assign epcr_o = mepc_q;

  // Loop write goes out as a single-cycle pulse
  assign hwlp_wr_o.valid = write_en && is_hwlp;
  assign hwlp_wr_o.id    = hwlp_id;
  assign hwlp_wr_o.field = hwlp_field;
  assign hwlp_wr_o.data  = new_value;

endmodule

/* csr_config.svh */
////////////////////////////////////////////////////////////
// Build-time constants of the CSR block and the loop bank
// Loop count is fixed at 2; the loop decoder is built for it
// Loop j sits at HWLP_BASE + 4j (start, end, counter)
////////////////////////////////////////////////////////////

`ifndef CSR_CONFIG_SVH
`define CSR_CONFIG_SVH

// Number of hardware loops
`define HWLOOP_REGS        2

// Constant registers, read only space
`define CSR_ADDR_MCPUID    12'hF00
`define CSR_ADDR_MIMPID    12'hF01
`define CSR_ADDR_MHARTID   12'hF10

// Machine registers
`define CSR_ADDR_MSCRATCH  12'h340
`define CSR_ADDR_MEPC      12'h341

// First loop register
`define CSR_ADDR_HWLP_BASE 12'h7B0

// RV32I base ISA, anonymous implementation
`define CSR_MCPUID_VAL     32'h0000_0100
`define CSR_MIMPID_VAL     32'h0000_8000

`endif

/* csr_pkg.sv */
////////////////////////////////////////////////////////////
// Types of the CSR access path
// One request per cycle, no handshake
////////////////////////////////////////////////////////////

package csr_pkg;

  // CSR address space
  typedef logic [11:0] csr_addr_t;

  // Register contents and program counters
  typedef logic [31:0] csr_data_t;

  // Core or cluster index
  typedef logic [4:0] hart_id_t;

  // Access operation, NONE means plain read
  typedef enum logic [1:0] {
    NONE  = 2'b00,
    WRITE = 2'b01,
    SET   = 2'b10,
    CLEAR = 2'b11
  } csr_op_e;

  // Single-cycle SRAM-like request, 46 bits
  typedef struct packed {
    csr_addr_t addr;
    csr_data_t wdata;
    csr_op_e   op;
  } csr_req_t;

endpackage

/* csr_subsystem.f */
+incdir+.
csr_pkg.sv
hwlp_pkg.sv
cs_registers.sv
hwlp_regfile.sv
csr_subsystem.sv
csr_subsystem_properties.sv
csr_subsystem_tb.sv

/* csr_subsystem.sv */
////////////////////////////////////////////////////////////
// CSR file together with the hardware loop bank
// Loop state is exported for the fetch logic
////////////////////////////////////////////////////////////

`include "csr_config.svh"

module csr_subsystem
(
  input  logic                                   clk,
  input  logic                                   rst_n,
  input  csr_pkg::hart_id_t                      core_id_i,
  input  csr_pkg::hart_id_t                      cluster_id_i,
  input  csr_pkg::csr_req_t                      csr_req_i,
  output csr_pkg::csr_data_t                     csr_rdata_o,
  output logic                                   csr_illegal_o,
  input  csr_pkg::csr_data_t                     curr_pc_if_i,
  input  csr_pkg::csr_data_t                     curr_pc_id_i,
  input  logic                                   save_pc_if_i,
  input  logic                                   save_pc_id_i,
  output csr_pkg::csr_data_t                     epcr_o,
  input  logic [`HWLOOP_REGS-1:0]                hwlp_dec_i,
  output csr_pkg::csr_data_t [`HWLOOP_REGS-1:0]  hwlp_start_o,
  output csr_pkg::csr_data_t [`HWLOOP_REGS-1:0]  hwlp_end_o,
  output csr_pkg::csr_data_t [`HWLOOP_REGS-1:0]  hwlp_counter_o
);

  // Merged loop write, CSR file to bank
  hwlp_pkg::hwlp_wr_t hwlp_wr;

  cs_registers u_cs_registers (
    .clk            (clk),
    .rst_n          (rst_n),
    .core_id_i      (core_id_i),
    .cluster_id_i   (cluster_id_i),
    .csr_req_i      (csr_req_i),
    .csr_rdata_o    (csr_rdata_o),
    .csr_illegal_o  (csr_illegal_o),
    .curr_pc_if_i   (curr_pc_if_i),
    .curr_pc_id_i   (curr_pc_id_i),
    .save_pc_if_i   (save_pc_if_i),
    .save_pc_id_i   (save_pc_id_i),
    .epcr_o         (epcr_o),
    .hwlp_start_i   (hwlp_start_o),
    .hwlp_end_i     (hwlp_end_o),
    .hwlp_counter_i (hwlp_counter_o),
    .hwlp_wr_o      (hwlp_wr)
  );

  hwlp_regfile u_hwlp_regfile (
    .clk            (clk),
    .rst_n          (rst_n),
    .hwlp_wr_i      (hwlp_wr),
    .hwlp_dec_i     (hwlp_dec_i),
    .hwlp_start_o   (hwlp_start_o),
    .hwlp_end_o     (hwlp_end_o),
    .hwlp_counter_o (hwlp_counter_o)
  );

endmodule

/* csr_subsystem_properties.sv */
////////////////////////////////////////////////////////////
// Port-level assertions for the CSR subsystem
// Bound into csr_subsystem, idle while reset is low
////////////////////////////////////////////////////////////

`include "csr_config.svh"

module csr_subsystem_properties
(
  input  logic                                   clk,
  input  logic                                   rst_n,
  input  csr_pkg::csr_req_t                      csr_req_i,
  input  csr_pkg::csr_data_t                     csr_rdata_o,
  input  logic                                   csr_illegal_o,
  input  csr_pkg::csr_data_t                     curr_pc_if_i,
  input  csr_pkg::csr_data_t                     curr_pc_id_i,
  input  logic                                   save_pc_if_i,
  input  logic                                   save_pc_id_i,
  input  csr_pkg::csr_data_t                     epcr_o,
  input  logic [`HWLOOP_REGS-1:0]                hwlp_dec_i,
  input  csr_pkg::csr_data_t [`HWLOOP_REGS-1:0]  hwlp_counter_o
);

  // Unmapped reads give zero
  illegal_reads_zero: assert property (@(posedge clk) disable iff (!rst_n)
    csr_illegal_o |-> (csr_rdata_o == '0))
    else $error("illegal read returned nonzero data");

  // IF save wins over ID save
  save_if_loads_epc: assert property (@(posedge clk) disable iff (!rst_n)
    save_pc_if_i |=> (epcr_o == $past(curr_pc_if_i)))
    else $error("IF save not captured in MEPC");

  save_id_loads_epc: assert property (@(posedge clk) disable iff (!rst_n)
    (!save_pc_if_i && save_pc_id_i) |=> (epcr_o == $past(curr_pc_id_i)))
    else $error("ID save not captured in MEPC");

  for (genvar j = 0; j < `HWLOOP_REGS; j++)
  begin : g_loop
    logic cnt_wr;

    // CSR access that targets this counter
    assign cnt_wr = (csr_req_i.op != csr_pkg::NONE) &&
                    (csr_req_i.addr == 12'(`CSR_ADDR_HWLP_BASE + 4 * j + 2));

    counter_drops_one: assert property (@(posedge clk) disable iff (!rst_n)
      (hwlp_dec_i[j] && (hwlp_counter_o[j] != '0) && !cnt_wr) |=>
      (hwlp_counter_o[j] == $past(hwlp_counter_o[j]) - 32'd1))
      else $error("loop counter did not drop by one");
  end

endmodule

/* csr_subsystem_tb.sv */
////////////////////////////////////////////////////////////
// Testbench of the CSR subsystem
// A mirror of every register predicts each cycle
// Directed tests first, then an LFSR driven mix
////////////////////////////////////////////////////////////

`include "csr_config.svh"

module csr_subsystem_tb;

  logic                                   clk;
  logic                                   rst_n;
  csr_pkg::hart_id_t                      core_id;
  csr_pkg::hart_id_t                      cluster_id;
  csr_pkg::csr_req_t                      req;
  csr_pkg::csr_data_t                     rdata;
  logic                                   illegal;
  csr_pkg::csr_data_t                     pc_if;
  csr_pkg::csr_data_t                     pc_id;
  logic                                   save_if;
  logic                                   save_id;
  csr_pkg::csr_data_t                     epcr;
  logic [`HWLOOP_REGS-1:0]                dec;
  csr_pkg::csr_data_t [`HWLOOP_REGS-1:0]  hw_start;
  csr_pkg::csr_data_t [`HWLOOP_REGS-1:0]  hw_end;
  csr_pkg::csr_data_t [`HWLOOP_REGS-1:0]  hw_cnt;

  // Mirror of the register state
  csr_pkg::csr_data_t mscratch_m;
  csr_pkg::csr_data_t mepc_m;
  csr_pkg::csr_data_t start_m [`HWLOOP_REGS];
  csr_pkg::csr_data_t end_m [`HWLOOP_REGS];
  csr_pkg::csr_data_t cnt_m [`HWLOOP_REGS];

  logic        check_en;
  int          err_count;
  int          check_count;
  int          test_errs;
  string       test_name;
  logic [31:0] lfsr_q;

  csr_subsystem DUT (
    .clk            (clk),
    .rst_n          (rst_n),
    .core_id_i      (core_id),
    .cluster_id_i   (cluster_id),
    .csr_req_i      (req),
    .csr_rdata_o    (rdata),
    .csr_illegal_o  (illegal),
    .curr_pc_if_i   (pc_if),
    .curr_pc_id_i   (pc_id),
    .save_pc_if_i   (save_if),
    .save_pc_id_i   (save_id),
    .epcr_o         (epcr),
    .hwlp_dec_i     (dec),
    .hwlp_start_o   (hw_start),
    .hwlp_end_o     (hw_end),
    .hwlp_counter_o (hw_cnt)
  );

  bind csr_subsystem csr_subsystem_properties u_props (
    .clk            (clk),
    .rst_n          (rst_n),
    .csr_req_i      (csr_req_i),
    .csr_rdata_o    (csr_rdata_o),
    .csr_illegal_o  (csr_illegal_o),
    .curr_pc_if_i   (curr_pc_if_i),
    .curr_pc_id_i   (curr_pc_id_i),
    .save_pc_if_i   (save_pc_if_i),
    .save_pc_id_i   (save_pc_id_i),
    .epcr_o         (epcr_o),
    .hwlp_dec_i     (hwlp_dec_i),
    .hwlp_counter_o (hwlp_counter_o)
  );

  // Period 4
  always #2 clk = ~clk;

  ////////////////////////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////////////////////////

  // Expected read data and illegal flag from the mirror
  function automatic csr_pkg::csr_data_t ref_read(input csr_pkg::csr_addr_t addr,
                                                  output logic ill);
    csr_pkg::csr_data_t rd;
    rd  = '0;
    ill = 1'b1;
    if (addr == `CSR_ADDR_MCPUID)
    begin
      rd  = `CSR_MCPUID_VAL;
      ill = 1'b0;
    end
    if (addr == `CSR_ADDR_MIMPID)
    begin
      rd  = `CSR_MIMPID_VAL;
      ill = 1'b0;
    end
    if (addr == `CSR_ADDR_MHARTID)
    begin
      rd  = {22'b0, cluster_id, core_id};
      ill = 1'b0;
    end
    if (addr == `CSR_ADDR_MSCRATCH)
    begin
      rd  = mscratch_m;
      ill = 1'b0;
    end
    if (addr == `CSR_ADDR_MEPC)
    begin
      rd  = mepc_m;
      ill = 1'b0;
    end
    for (int j = 0; j < `HWLOOP_REGS; j++)
    begin
      if (addr == 12'(`CSR_ADDR_HWLP_BASE + 4 * j))
      begin
        rd  = start_m[j];
        ill = 1'b0;
      end
      if (addr == 12'(`CSR_ADDR_HWLP_BASE + 4 * j + 1))
      begin
        rd  = end_m[j];
        ill = 1'b0;
      end
      if (addr == 12'(`CSR_ADDR_HWLP_BASE + 4 * j + 2))
      begin
        rd  = cnt_m[j];
        ill = 1'b0;
      end
    end
    return rd;
  endfunction

  // Next mirror state from the inputs at this edge
  task automatic step_mirror();
    logic               ill;
    logic               wen;
    logic               cnt_written;
    csr_pkg::csr_data_t old_v;
    csr_pkg::csr_data_t new_v;
    old_v = ref_read(req.addr, ill);
    case (req.op)
      csr_pkg::WRITE: new_v = req.wdata;
      csr_pkg::SET:   new_v = old_v | req.wdata;
      csr_pkg::CLEAR: new_v = old_v & ~req.wdata;
      default:        new_v = old_v;
    endcase
    wen = (req.op != csr_pkg::NONE) && (req.addr[11:10] != 2'b11) && !ill;
    if (wen && (req.addr == `CSR_ADDR_MSCRATCH))
      mscratch_m = new_v;
    if (save_if)
      mepc_m = pc_if;
    else if (save_id)
      mepc_m = pc_id;
    else if (wen && (req.addr == `CSR_ADDR_MEPC))
      mepc_m = new_v;
    for (int j = 0; j < `HWLOOP_REGS; j++)
    begin
      cnt_written = 1'b0;
      if (wen && (req.addr == 12'(`CSR_ADDR_HWLP_BASE + 4 * j)))
        start_m[j] = new_v;
      if (wen && (req.addr == 12'(`CSR_ADDR_HWLP_BASE + 4 * j + 1)))
        end_m[j] = new_v;
      if (wen && (req.addr == 12'(`CSR_ADDR_HWLP_BASE + 4 * j + 2)))
      begin
        cnt_m[j]    = new_v;
        cnt_written = 1'b1;
      end
      if (!cnt_written && dec[j] && (cnt_m[j] != '0))
        cnt_m[j] = cnt_m[j] - 32'd1;
    end
  endtask

  task automatic report_value(input string what, input logic [31:0] exp_v,
                              input logic [31:0] act_v);
    err_count++;
    $display("[ERROR] %s %s: expected %h actual %h", test_name, what, exp_v, act_v);
  endtask

  // Outputs before the edge against the mirror
  task automatic compare_outputs();
    logic               exp_ill;
    csr_pkg::csr_data_t exp_rd;
    exp_rd = ref_read(req.addr, exp_ill);
    check_count++;
    if (rdata !== exp_rd)
      report_value("rdata", exp_rd, rdata);
    if (illegal !== exp_ill)
      report_value("illegal", 32'(exp_ill), 32'(illegal));
    if (epcr !== mepc_m)
      report_value("epcr", mepc_m, epcr);
    for (int j = 0; j < `HWLOOP_REGS; j++)
    begin
      if (hw_start[j] !== start_m[j])
        report_value($sformatf("start[%0d]", j), start_m[j], hw_start[j]);
      if (hw_end[j] !== end_m[j])
        report_value($sformatf("end[%0d]", j), end_m[j], hw_end[j]);
      if (hw_cnt[j] !== cnt_m[j])
        report_value($sformatf("counter[%0d]", j), cnt_m[j], hw_cnt[j]);
    end
  endtask

  always @(posedge clk)
  begin
    if (check_en)
    begin
      compare_outputs();
      step_mirror();
    end
  end

  ////////////////////////////////////////////////////////////
  // Stimulus helpers
  ////////////////////////////////////////////////////////////

  // Fibonacci LFSR with taps 32 22 2 1
  task automatic take_bits(input int n, output logic [31:0] value);
    logic fb;
    value = '0;
    for (int i = 0; i < n; i++)
    begin
      fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
      lfsr_q = {lfsr_q[30:0], fb};
      value  = {value[30:0], fb};
    end
  endtask

  function automatic csr_pkg::csr_addr_t legal_addr(input int idx);
    case (idx)
      0:       return `CSR_ADDR_MCPUID;
      1:       return `CSR_ADDR_MIMPID;
      2:       return `CSR_ADDR_MHARTID;
      3:       return `CSR_ADDR_MSCRATCH;
      4:       return `CSR_ADDR_MEPC;
      5:       return 12'h7B0;
      6:       return 12'h7B1;
      7:       return 12'h7B2;
      8:       return 12'h7B4;
      9:       return 12'h7B5;
      default: return 12'h7B6;
    endcase
  endfunction

  task automatic drive(input csr_pkg::csr_addr_t addr, input csr_pkg::csr_op_e op,
                       input csr_pkg::csr_data_t wdata, input logic s_if,
                       input logic s_id, input logic [`HWLOOP_REGS-1:0] d);
    @(negedge clk);
    req.addr  = addr;
    req.op    = op;
    req.wdata = wdata;
    save_if   = s_if;
    save_id   = s_id;
    dec       = d;
  endtask

  task automatic access(input csr_pkg::csr_addr_t addr, input csr_pkg::csr_op_e op,
                        input csr_pkg::csr_data_t wdata);
    drive(addr, op, wdata, 1'b0, 1'b0, '0);
  endtask

  task automatic begin_test(input string name);
    test_name = name;
    test_errs = err_count;
  endtask

  // Idle cycle and a wait until it has been checked
  task automatic end_test();
    int target;
    int waited;
    access(12'h000, csr_pkg::NONE, '0);
    target = check_count + 1;
    waited = 0;
    while (check_count < target)
    begin
      @(posedge clk);
      #1;
      waited++;
      if (waited > 50)
      begin
        $display("timeout: compare process stalled in %s", test_name);
        $display("sim failed");
        $finish;
      end
    end
    $display("test %s done, %0d errors", test_name, err_count - test_errs);
  endtask

  ////////////////////////////////////////////////////////////
  // Tests
  ////////////////////////////////////////////////////////////

  task automatic run_random(input int cycles);
    logic [31:0]             v;
    csr_pkg::csr_addr_t      addr;
    csr_pkg::csr_op_e        op;
    csr_pkg::csr_data_t      wdata;
    logic                    s_if;
    logic                    s_id;
    logic [`HWLOOP_REGS-1:0] d;
    for (int n = 0; n < cycles; n++)
    begin
      take_bits(1, v);
      if (v[0])
      begin
        take_bits(4, v);
        addr = legal_addr(int'(v % 11));
      end
      else
      begin
        take_bits(12, v);
        addr = v[11:0];
      end
      take_bits(2, v);
      op = csr_pkg::csr_op_e'(v[1:0]);
      take_bits(32, v);
      wdata = v;
      // Small counts so decrements reach zero
      take_bits(1, v);
      if (v[0])
        wdata[31:3] = '0;
      take_bits(3, v);
      s_if = (v[2:0] == 3'd7);
      take_bits(3, v);
      s_id = (v[2:0] == 3'd7);
      for (int j = 0; j < `HWLOOP_REGS; j++)
      begin
        take_bits(2, v);
        d[j] = (v[1:0] == 2'd3);
      end
      drive(addr, op, wdata, s_if, s_id, d);
      // Exception PCs for the request just driven
      take_bits(32, v);
      pc_if = v;
      take_bits(32, v);
      pc_id = v;
    end
  endtask

  initial
  begin
    clk        = 1'b0;
    rst_n      = 1'b0;
    core_id    = 5'h13;
    cluster_id = 5'h0A;
    req        = '0;
    pc_if      = '0;
    pc_id      = '0;
    save_if    = 1'b0;
    save_id    = 1'b0;
    dec        = '0;
    check_en   = 1'b0;
    err_count  = 0;
    check_count = 0;
    lfsr_q     = 32'h377b;
    mscratch_m = '0;
    mepc_m     = '0;
    for (int j = 0; j < `HWLOOP_REGS; j++)
    begin
      start_m[j] = '0;
      end_m[j]   = '0;
      cnt_m[j]   = '0;
    end
    repeat (4) @(negedge clk);
    rst_n    = 1'b1;
    check_en = 1'b1;

    begin_test("constants");
    access(`CSR_ADDR_MCPUID, csr_pkg::NONE, '0);
    access(`CSR_ADDR_MIMPID, csr_pkg::NONE, '0);
    access(`CSR_ADDR_MHARTID, csr_pkg::NONE, '0);
    access(`CSR_ADDR_MCPUID, csr_pkg::WRITE, 32'hFFFF_FFFF);
    access(`CSR_ADDR_MIMPID, csr_pkg::SET, 32'h1234_5678);
    access(`CSR_ADDR_MHARTID, csr_pkg::CLEAR, 32'hFFFF_FFFF);
    access(`CSR_ADDR_MHARTID, csr_pkg::NONE, '0);
    end_test();

    begin_test("operations");
    access(`CSR_ADDR_MSCRATCH, csr_pkg::WRITE, 32'hA5A5_0F0F);
    access(`CSR_ADDR_MSCRATCH, csr_pkg::NONE, 32'hFFFF_FFFF);
    access(`CSR_ADDR_MSCRATCH, csr_pkg::SET, 32'h0000_FFFF);
    access(`CSR_ADDR_MSCRATCH, csr_pkg::CLEAR, 32'h00FF_00FF);
    access(`CSR_ADDR_MSCRATCH, csr_pkg::NONE, '0);
    end_test();

    begin_test("exception_pc");
    drive(`CSR_ADDR_MEPC, csr_pkg::NONE, '0, 1'b1, 1'b0, '0);
    // PCs belong to the request just driven
    pc_if = 32'h0000_1000;
    pc_id = 32'h0000_2000;
    drive(`CSR_ADDR_MEPC, csr_pkg::NONE, '0, 1'b0, 1'b1, '0);
    drive(`CSR_ADDR_MEPC, csr_pkg::NONE, '0, 1'b1, 1'b1, '0);
    pc_if = 32'h0000_3000;
    drive(`CSR_ADDR_MEPC, csr_pkg::WRITE, 32'hDEAD_BEEF, 1'b0, 1'b1, '0);
    drive(`CSR_ADDR_MEPC, csr_pkg::WRITE, 32'hCAFE_0000, 1'b1, 1'b0, '0);
    access(`CSR_ADDR_MEPC, csr_pkg::SET, 32'h0000_00F0);
    access(`CSR_ADDR_MEPC, csr_pkg::NONE, '0);
    end_test();

    begin_test("hw_loops");
    for (int j = 0; j < `HWLOOP_REGS; j++)
    begin
      for (int k = 0; k < 3; k++)
      begin
        access(12'(`CSR_ADDR_HWLP_BASE + 4 * j + k), csr_pkg::WRITE,
               32'h1000_0000 * (j + 1) + 32'h100 * k + 32'h0F);
        access(12'(`CSR_ADDR_HWLP_BASE + 4 * j + k), csr_pkg::SET, 32'h00F0_0F00);
        access(12'(`CSR_ADDR_HWLP_BASE + 4 * j + k), csr_pkg::CLEAR, 32'h0000_0F0F);
        access(12'(`CSR_ADDR_HWLP_BASE + 4 * j + k), csr_pkg::NONE, '0);
      end
    end
    end_test();

    begin_test("loop_decrement");
    access(12'h7B2, csr_pkg::WRITE, 32'd2);
    drive(12'h7B2, csr_pkg::NONE, '0, 1'b0, 1'b0, 2'b01);
    drive(12'h7B2, csr_pkg::NONE, '0, 1'b0, 1'b0, 2'b01);
    drive(12'h7B2, csr_pkg::NONE, '0, 1'b0, 1'b0, 2'b01);
    drive(12'h7B6, csr_pkg::WRITE, 32'd5, 1'b0, 1'b0, 2'b10);
    drive(12'h7B6, csr_pkg::NONE, '0, 1'b0, 1'b0, 2'b11);
    drive(12'h7B2, csr_pkg::SET, 32'd1, 1'b0, 1'b0, 2'b11);
    access(12'h7B6, csr_pkg::NONE, '0);
    end_test();

    begin_test("random_mix");
    run_random(2000);
    end_test();

    $display("checks %0d, errors %0d", check_count, err_count);
    if ((err_count == 0) && (check_count > 0))
    begin
      $display("sim passed");
    end
    else
    begin
      $display("sim failed");
    end
    $finish;
  end

  // Watchdog for the whole run
  initial
  begin
    for (int n = 0; n < 20000; n++)
    begin
      @(posedge clk);
    end
    $display("timeout: run did not finish in 20000 cycles");
    $display("sim failed");
    $finish;
  end

endmodule

/* hwlp_pkg.sv */
////////////////////////////////////////////////////////////
// Types of the hardware loop write path
// Needs csr_pkg compiled first for the data word
////////////////////////////////////////////////////////////

`include "csr_config.svh"

package hwlp_pkg;

  // Loop index width, at least one bit
  localparam int unsigned HWLP_ID_W = (`HWLOOP_REGS > 1) ? $clog2(`HWLOOP_REGS) : 1;

  typedef logic [HWLP_ID_W-1:0] hwlp_id_t;

  // Field within one loop, matches address offset bits [1:0]
  typedef enum logic [1:0] {
    START   = 2'd0,
    END     = 2'd1,
    COUNTER = 2'd2
  } hwlp_field_e;

  // Final value to store, already merged by the CSR file
  typedef struct packed {
    logic               valid;
    hwlp_id_t           id;
    hwlp_field_e        field;
    csr_pkg::csr_data_t data;
  } hwlp_wr_t;

endpackage

/* hwlp_regfile.sv */
////////////////////////////////////////////////////////////
// Hardware loop bank: start, end and counter per loop
// A CSR write to a counter beats its decrement
// A zero counter ignores the decrement pulse
////////////////////////////////////////////////////////////

`include "csr_config.svh"

module hwlp_regfile
(
  input  logic                                   clk,
  input  logic                                   rst_n,

  // Merged write from the CSR file
  input  hwlp_pkg::hwlp_wr_t                     hwlp_wr_i,

  // End of loop reached, one bit per loop
  input  logic [`HWLOOP_REGS-1:0]                hwlp_dec_i,

  output csr_pkg::csr_data_t [`HWLOOP_REGS-1:0]  hwlp_start_o,
  output csr_pkg::csr_data_t [`HWLOOP_REGS-1:0]  hwlp_end_o,
  output csr_pkg::csr_data_t [`HWLOOP_REGS-1:0]  hwlp_counter_o
);

  csr_pkg::csr_data_t [`HWLOOP_REGS-1:0] start_q;
  csr_pkg::csr_data_t [`HWLOOP_REGS-1:0] end_q;
  csr_pkg::csr_data_t [`HWLOOP_REGS-1:0] counter_q;

  // Per-loop write hit
  logic [`HWLOOP_REGS-1:0] loop_hit;

  always_comb
  begin
    for (int i = 0; i < `HWLOOP_REGS; i++)
    begin
      loop_hit[i] = hwlp_wr_i.valid && (hwlp_wr_i.id == hwlp_pkg::hwlp_id_t'(i));
    end
  end

  ////////////////////////////////////////////////////////////
  // Register update
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      start_q   <= '0;
      end_q     <= '0;
      counter_q <= '0;
    end
    else
    begin
      for (int i = 0; i < `HWLOOP_REGS; i++)
      begin
        if (loop_hit[i] && (hwlp_wr_i.field == hwlp_pkg::START))
          start_q[i] <= hwlp_wr_i.data;

        if (loop_hit[i] && (hwlp_wr_i.field == hwlp_pkg::END))
          end_q[i] <= hwlp_wr_i.data;

        // Write first, otherwise count down
        if (loop_hit[i] && (hwlp_wr_i.field == hwlp_pkg::COUNTER))
          counter_q[i] <= hwlp_wr_i.data;
        else if (hwlp_dec_i[i] && (counter_q[i] != '0))
          counter_q[i] <= counter_q[i] - 32'd1;
      end
    end
  end

  assign hwlp_start_o   = start_q;
  assign hwlp_end_o     = end_q;
  assign hwlp_counter_o = counter_q;

endmodule
